// ==== Bender.yml ====
package:
  name: tdc_spi

sources:
  - src/tdc_pkg.sv
  - src/synchronizer.sv
  - src/spi_peripheral.sv
  - src/reg_bank.sv
  - src/tdc.sv
  - src/tdc_spi_top.sv
  - target: test
    files:
      - verification/tdc_spi_tb.sv

// ==== filelist.f ====
src/tdc_pkg.sv
src/synchronizer.sv
src/spi_peripheral.sv
src/reg_bank.sv
src/tdc.sv
src/tdc_spi_top.sv
verification/tdc_spi_tb.sv

// ==== src/reg_bank.sv ====
`timescale 1ns/100ps

module reg_bank import tdc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  reg_req_t    req,
  input  tdc_result_t result,
  output reg_t        rd_data,
  output logic        enable,
  output cfg_regs_t   cfg_regs
);

  cfg_regs_t    cfg_q;
  status_regs_t status;

  // Configuration writes, status space is read only
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
    end else if (req.we && req.space == SPACE_CFG) begin
      cfg_q[req.addr] <= req.wdata;
    end
  end

  // Status words from the TDC result
  always_comb begin
    status = '0;
    // Coarse count little endian in the low registers
    for (int i = 0; i < COARSE_WIDTH / REG_WIDTH; i++) begin
      status[i] = result.coarse[i*REG_WIDTH +: REG_WIDTH];
    end
    status[STATUS_FINE_LO] = result.fine[REG_WIDTH-1:0];
    // Top fine bit shares a register with busy
    status[STATUS_FINE_HI][FINE_WIDTH-REG_WIDTH-1:0] = result.fine[FINE_WIDTH-1:REG_WIDTH];
    status[STATUS_FINE_HI][STATUS_BUSY_BIT]          = result.busy;
  end

  // Read mux follows the latched SPI command
  always_comb begin
    if (req.space == SPACE_STATUS) begin
      rd_data = status[req.addr];
    end else begin
      rd_data = cfg_q[req.addr];
    end
  end

  assign enable   = cfg_q[CFG_CTRL][CTRL_ENABLE_BIT];
  assign cfg_regs = cfg_q;

endmodule

// ==== src/spi_peripheral.sv ====
`timescale 1ns/100ps

module spi_peripheral import tdc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  spi_pins_t pins,
  input  reg_t      rd_data,
  output reg_req_t  req,
  output logic      miso
);

  // Counter must reach FRAME_BITS itself
  localparam int CNT_WIDTH = $clog2(FRAME_BITS + 1);

  logic                 sclk_q;
  logic                 sclk_rise;
  logic                 sclk_fall;
  logic                 sample_edge;
  logic                 shift_edge;
  logic [CNT_WIDTH-1:0] bit_cnt;
  logic [CNT_WIDTH-1:0] first_shift;
  logic                 shift_active;
  logic                 cmd_write;
  logic                 load_pending;
  reg_t                 rx_shift;
  reg_t                 rx_next;
  reg_t                 tx_shift;

  // Edges of the synchronized sclk
  assign sclk_rise = pins.sclk & ~sclk_q;
  assign sclk_fall = ~pins.sclk & sclk_q;

  // Modes 0 and 3 sample on rising sclk
  // Modes 1 and 2 sample on falling sclk
  assign sample_edge = (pins.cpol == pins.cpha) ? sclk_rise : sclk_fall;
  assign shift_edge  = (pins.cpol == pins.cpha) ? sclk_fall : sclk_rise;

  // Byte as it stands after the current MOSI bit
  assign rx_next = {rx_shift[REG_WIDTH-2:0], pins.mosi};

  // With cpha 0 bit 7 is already out at load time
  assign first_shift = pins.cpha ? CNT_WIDTH'(REG_WIDTH) : CNT_WIDTH'(REG_WIDTH + 1);

  // Shift edges that move the read byte onto MISO
  assign shift_active = shift_edge && (bit_cnt >= first_shift) &&
                        (bit_cnt < CNT_WIDTH'(FRAME_BITS));

  // Frame control and register request
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_q       <= 1'b0;
      bit_cnt      <= '0;
      cmd_write    <= 1'b0;
      load_pending <= 1'b0;
      req          <= '0;
      miso         <= 1'b0;
    end else begin
      sclk_q       <= pins.sclk;
      req.we       <= 1'b0;
      load_pending <= 1'b0;
      if (pins.cs_n) begin
        // Deselected, any partial frame is dropped
        bit_cnt   <= '0;
        cmd_write <= 1'b0;
        miso      <= 1'b0;
      end else begin
        if (sample_edge && bit_cnt < CNT_WIDTH'(FRAME_BITS)) begin
          bit_cnt <= bit_cnt + 1'b1;
          // Command byte complete
          if (bit_cnt == CNT_WIDTH'(REG_WIDTH - 1)) begin
            cmd_write    <= rx_next[CMD_WRITE_BIT];
            req.space    <= rx_next[CMD_SPACE_BIT];
            req.addr     <= rx_next[ADDR_WIDTH-1:0];
            load_pending <= 1'b1;
          end
          // Data byte complete, one cycle write strobe
          if (bit_cnt == CNT_WIDTH'(FRAME_BITS - 1) && cmd_write) begin
            req.we    <= 1'b1;
            req.wdata <= rx_next;
          end
        end
        if (load_pending) begin
          // cpha 0 needs bit 7 before the next sample edge
          if (!pins.cpha) begin
            miso <= rd_data[REG_WIDTH-1];
          end
        end else if (shift_active) begin
          miso <= tx_shift[REG_WIDTH-1];
        end
      end
    end
  end

  // MOSI shifter
  always_ff @(posedge clk) begin
    if (!pins.cs_n && sample_edge) begin
      rx_shift <= rx_next;
    end
  end

  // MISO shifter, rd_data is valid once the address has settled
  always_ff @(posedge clk) begin
    if (load_pending) begin
      tx_shift <= pins.cpha ? rd_data : {rd_data[REG_WIDTH-2:0], 1'b0};
    end else if (shift_active) begin
      tx_shift <= {tx_shift[REG_WIDTH-2:0], 1'b0};
    end
  end

endmodule

// ==== src/synchronizer.sv ====
`timescale 1ns/100ps

module synchronizer import tdc_pkg::*; #(
  parameter type data_t = logic
) (
  input  logic  clk,
  input  logic  rst,
  input  data_t d,
  output data_t q
);

  // Flop chain, stage 0 sees the asynchronous input
  data_t stages [SYNC_STAGES];

  always_ff @(posedge clk) begin
    if (rst) begin
      stages <= '{default: '0};
    end else begin
      stages[0] <= d;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // Last stage is safe to use in the clk domain
  assign q = stages[SYNC_STAGES-1];

endmodule

// ==== src/tdc.sv ====
`timescale 1ns/100ps

module tdc import tdc_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  tdc_pins_t   pins,
  input  logic        enable,
  output tdc_result_t result
);

  // One cycle history for edge detection
  tdc_pins_t pins_q;
  logic      start_rise;
  logic      stop_rise;
  logic      sample_rise;
  logic      fine_full;

  assign start_rise  = pins.start & ~pins_q.start;
  assign stop_rise   = pins.stop & ~pins_q.stop;
  assign sample_rise = pins.sampling & ~pins_q.sampling;

  // Fine counter sticks at its top value
  assign fine_full = (result.fine == FINE_WIDTH'(FINE_MAX));

  always_ff @(posedge clk) begin
    if (rst) begin
      pins_q <= '0;
    end else begin
      pins_q <= pins;
    end
  end

  // Measurement window
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (!result.busy) begin
      // Idle, wait for an enabled start
      if (enable && start_rise) begin
        result.busy   <= 1'b1;
        result.coarse <= '0;
        result.fine   <= '0;
      end
    end else begin
      // Stop cycle still counts, so coarse equals the raw edge spacing
      result.coarse <= result.coarse + 1'b1;
      if (sample_rise && !fine_full) begin
        result.fine <= result.fine + 1'b1;
      end
      // Counters hold once busy drops
      if (stop_rise) begin
        result.busy <= 1'b0;
      end
    end
  end

endmodule

// ==== src/tdc_pkg.sv ====
package tdc_pkg;

  // Synchronizer depth
  localparam int SYNC_STAGES = 2;

  // Register file geometry
  localparam int NUM_CFG    = 8;
  localparam int NUM_STATUS = 8;
  localparam int REG_WIDTH  = 8;
  localparam int ADDR_WIDTH = 3;

  // Measurement widths, fine count saturates at all ones
  localparam int COARSE_WIDTH = 32;
  localparam int FINE_WIDTH   = 9;
  localparam int FINE_MAX     = (1 << FINE_WIDTH) - 1;

  // SPI frame is command byte plus data byte
  localparam int FRAME_BITS    = 16;
  localparam int CMD_WRITE_BIT = 7;
  localparam int CMD_SPACE_BIT = 6;

  // Register spaces
  localparam logic SPACE_CFG    = 1'b0;
  localparam logic SPACE_STATUS = 1'b1;

  // Register map
  localparam int CFG_CTRL        = 0;
  localparam int CTRL_ENABLE_BIT = 0;
  localparam int STATUS_FINE_LO  = 4;
  localparam int STATUS_FINE_HI  = 5;
  localparam int STATUS_BUSY_BIT = 1;

  typedef logic [REG_WIDTH-1:0]  reg_t;
  typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
  typedef reg_t [NUM_CFG-1:0]    cfg_regs_t;
  typedef reg_t [NUM_STATUS-1:0] status_regs_t;

  // Raw SPI pins, chip select active low
  typedef struct packed {
    logic cs_n;
    logic sclk;
    logic mosi;
    logic cpol;
    logic cpha;
  } spi_pins_t;

  typedef struct packed {
    logic start;
    logic stop;
    logic sampling;
  } tdc_pins_t;

  // Register access from the SPI side
  typedef struct packed {
    logic      we;
    logic      space;
    reg_addr_t addr;
    reg_t      wdata;
  } reg_req_t;

  typedef struct packed {
    logic [COARSE_WIDTH-1:0] coarse;
    logic [FINE_WIDTH-1:0]   fine;
    logic                    busy;
  } tdc_result_t;

endpackage

// ==== src/tdc_spi_top.sv ====
`timescale 1ns/100ps

module tdc_spi_top import tdc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  spi_pins_t spi_pins,
  input  tdc_pins_t tdc_pins,
  output logic      miso,
  output logic      busy,
  output cfg_regs_t cfg_regs
);

  // Synchronized pins
  spi_pins_t   spi_pins_sync;
  tdc_pins_t   tdc_pins_sync;

  // SPI to register bank
  reg_req_t    reg_req;
  reg_t        rd_data;

  // TDC side
  tdc_result_t tdc_result;
  logic        enable;

  synchronizer #(
    .data_t(spi_pins_t)
  ) spi_sync_i (
    .clk (clk),
    .rst (rst),
    .d   (spi_pins),
    .q   (spi_pins_sync)
  );

  synchronizer #(
    .data_t(tdc_pins_t)
  ) tdc_sync_i (
    .clk (clk),
    .rst (rst),
    .d   (tdc_pins),
    .q   (tdc_pins_sync)
  );

  spi_peripheral spi_peripheral_i (
    .clk     (clk),
    .rst     (rst),
    .pins    (spi_pins_sync),
    .rd_data (rd_data),
    .req     (reg_req),
    .miso    (miso)
  );

  reg_bank reg_bank_i (
    .clk      (clk),
    .rst      (rst),
    .req      (reg_req),
    .result   (tdc_result),
    .rd_data  (rd_data),
    .enable   (enable),
    .cfg_regs (cfg_regs)
  );

  tdc tdc_i (
    .clk    (clk),
    .rst    (rst),
    .pins   (tdc_pins_sync),
    .enable (enable),
    .result (tdc_result)
  );

  // Busy straight from the measurement FSM
  assign busy = tdc_result.busy;

endmodule

// ==== verification/tdc_spi_tb.sv ====
`timescale 1ns/100ps

module tdc_spi_tb import tdc_pkg::*; ();

  // SCLK half period in clk cycles
  localparam int HALF = 5;
  localparam int FRAME_CYCLES = 2 * HALF * (FRAME_BITS + 1) + 12;
  localparam int MAX_FRAMES = 160;
  // Saturation window is the longest measurement
  localparam int SAT_WINDOW = 2200;
  localparam int WATCHDOG_CYCLES = MAX_FRAMES * FRAME_CYCLES + SAT_WINDOW + 3000;

  logic        clk;
  logic        rst;
  spi_pins_t   spi_pins;
  tdc_pins_t   tdc_pins;
  logic        miso;
  logic        busy;
  cfg_regs_t   cfg_regs;
  logic [15:0] lfsr_state = 16'd22056;
  reg_t        cfg_model [NUM_CFG];

  tdc_spi_top tdc_spi_top_i (
    .clk      (clk),
    .rst      (rst),
    .spi_pins (spi_pins),
    .tdc_pins (tdc_pins),
    .miso     (miso),
    .busy     (busy),
    .cfg_regs (cfg_regs)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout, the tests ran past %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  // Taps at x^16 x^14 x^13 x^11 and one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0d ns %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  // Bit-banged SPI master sending MSB first and returning the second MISO byte
  task automatic spi_frame(input logic [1:0] mode, input logic [15:0] frame, output reg_t rx);
    logic cpol;
    logic cpha;
    cpol = mode[1];
    cpha = mode[0];
    rx = '0;
    // Mode and idle clock level settle while deselected
    spi_pins.cs_n = 1'b1;
    spi_pins.cpol = cpol;
    spi_pins.cpha = cpha;
    spi_pins.sclk = cpol;
    repeat (4) @(negedge clk);
    spi_pins.cs_n = 1'b0;
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      // cpha 1 shifts on the leading edge
      if (cpha) begin
        spi_pins.sclk = ~cpol;
      end
      spi_pins.mosi = frame[i];
      repeat (HALF) @(negedge clk);
      // MISO is stable just ahead of the sample edge
      if (i < REG_WIDTH) begin
        rx = {rx[REG_WIDTH-2:0], miso};
      end
      spi_pins.sclk = cpha ? cpol : ~cpol;
      repeat (HALF) @(negedge clk);
      if (!cpha) begin
        spi_pins.sclk = cpol;
      end
    end
    repeat (HALF) @(negedge clk);
    spi_pins.cs_n = 1'b1;
    // Room for the write strobe and the register update
    repeat (8) @(negedge clk);
  endtask

  task automatic write_reg(input logic [1:0] mode, input logic space, input reg_addr_t addr,
                           input reg_t data);
    reg_t unused;
    spi_frame(mode, {1'b1, space, 3'b000, addr, data}, unused);
  endtask

  task automatic read_reg(input logic [1:0] mode, input logic space, input reg_addr_t addr,
                          output reg_t data);
    spi_frame(mode, {1'b0, space, 3'b000, addr, 8'h00}, data);
  endtask

  // Status 0..3 coarse little endian, 4 fine low, 5 fine bit 8 and busy
  task automatic read_result(input logic [1:0] mode, output logic [31:0] coarse,
                             output logic [8:0] fine, output logic busy_bit);
    reg_t d;
    for (int a = 0; a < 4; a++) begin
      read_reg(mode, 1'b1, reg_addr_t'(a), d);
      coarse[a*8 +: 8] = d;
    end
    read_reg(mode, 1'b1, 3'd4, d);
    fine[7:0] = d;
    read_reg(mode, 1'b1, 3'd5, d);
    fine[8] = d[0];
    busy_bit = d[1];
    check(32'(d[7:2]), 0, "status 5 spare bits");
  endtask

  task automatic wait_idle;
    int waited;
    waited = 0;
    while (busy && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("Busy did not clear within 16 cycles of the stop edge");
      $display("TEST RESULT: FAIL");
      $fatal(1, "TDC stuck busy");
    end
  endtask

  // Start now and stop n cycles later with a sampling square wave in between
  task automatic run_window(input int n, input int period, input logic exp_busy,
                            output int edges);
    logic level;
    edges = 0;
    tdc_pins.start = 1'b1;
    for (int c = 1; c <= n; c++) begin
      @(negedge clk);
      // Two sync stages plus the edge register
      if (c >= 3) begin
        check(32'(busy), 32'(exp_busy), $sformatf("busy at cycle %0d of window", c));
      end
      if (c == n) begin
        tdc_pins.stop = 1'b1;
      end else if (period > 0) begin
        level = (c % period) >= (period / 2);
        if (level && !tdc_pins.sampling) begin
          edges++;
        end
        tdc_pins.sampling = level;
      end
    end
    wait_idle();
    tdc_pins = '0;
    repeat (4) @(negedge clk);
  endtask

  task automatic reset_values;
    reg_t d;
    check(32'(busy), 0, "busy after reset");
    check(32'(miso), 0, "miso after reset");
    for (int s = 0; s < 2; s++) begin
      for (int a = 0; a < NUM_CFG; a++) begin
        if (s == 0) begin
          check(32'(cfg_regs[a]), 0, $sformatf("cfg_regs[%0d] after reset", a));
        end
        read_reg(2'd0, s[0], reg_addr_t'(a), d);
        check(32'(d), 0, $sformatf("space %0d reg %0d after reset", s, a));
      end
    end
  endtask

  task automatic cfg_in_all_modes;
    reg_t      d;
    reg_addr_t sa;
    for (int m = 0; m < 4; m++) begin
      for (int a = 0; a < NUM_CFG; a++) begin
        cfg_model[a] = reg_t'(random_bits(8));
        write_reg(2'(m), 1'b0, reg_addr_t'(a), cfg_model[a]);
      end
      for (int a = 0; a < NUM_CFG; a++) begin
        check(32'(cfg_regs[a]), 32'(cfg_model[a]), $sformatf("cfg_regs[%0d] mode %0d", a, m));
        read_reg(2'(m), 1'b0, reg_addr_t'(a), d);
        check(32'(d), 32'(cfg_model[a]), $sformatf("cfg %0d readback mode %0d", a, m));
      end
      // Status space is read only
      sa = reg_addr_t'(random_bits(3));
      write_reg(2'(m), 1'b1, sa, reg_t'(random_bits(8)));
      for (int a = 0; a < NUM_CFG; a++) begin
        check(32'(cfg_regs[a]), 32'(cfg_model[a]), $sformatf("cfg %0d after status write", a));
      end
      read_reg(2'(m), 1'b1, sa, d);
      check(32'(d), 0, $sformatf("status %0d after write, mode %0d", sa, m));
    end
  endtask

  task automatic coarse_windows;
    int          n;
    int          edges;
    logic [31:0] coarse;
    logic [8:0]  fine;
    logic        b;
    cfg_model[0] = 8'h01;
    write_reg(2'd0, 1'b0, 3'd0, cfg_model[0]);
    for (int k = 0; k < 3; k++) begin
      n = 8 + int'(random_bits(6));
      run_window(n, 0, 1'b1, edges);
      read_result(2'(random_bits(2)), coarse, fine, b);
      check(coarse, n, $sformatf("coarse for window of %0d", n));
      check(32'(fine), 0, "fine without sampling edges");
      check(32'(b), 0, "busy bit after stop");
    end
  endtask

  task automatic fine_windows;
    int          edges;
    logic [31:0] coarse;
    logic [8:0]  fine;
    logic        b;
    run_window(120, 6, 1'b1, edges);
    read_result(2'd1, coarse, fine, b);
    check(coarse, 120, "coarse of fine window");
    check(32'(fine), edges, "fine edge count");
    // More than 511 rising edges must saturate
    run_window(SAT_WINDOW, 4, 1'b1, edges);
    read_result(2'd2, coarse, fine, b);
    check(coarse, SAT_WINDOW, "coarse of saturation window");
    check(32'(fine), 511, "saturated fine");
  endtask

  task automatic busy_mirror_and_disable;
    time         t0;
    int          n;
    int          edges;
    reg_t        d;
    logic [31:0] coarse;
    logic [8:0]  fine;
    logic        b;
    t0 = $time;
    tdc_pins.start = 1'b1;
    repeat (4) @(negedge clk);
    check(32'(busy), 1, "busy after start");
    // Busy bit read back while the window is open
    read_reg(2'd3, 1'b1, 3'd5, d);
    check(32'(d), 32'h02, "status 5 during measurement");
    tdc_pins.stop = 1'b1;
    n = int'(($time - t0) / 10);
    wait_idle();
    tdc_pins = '0;
    repeat (4) @(negedge clk);
    read_result(2'd3, coarse, fine, b);
    check(coarse, n, "coarse of mirror window");
    check(32'(b), 0, "status 5 busy after stop");
    cfg_model[0] = 8'h00;
    write_reg(2'd0, 1'b0, 3'd0, cfg_model[0]);
    check(32'(cfg_regs[0]), 0, "cfg 0 cleared");
    // Disabled start must not touch the results
    run_window(40, 4, 1'b0, edges);
    read_result(2'd0, coarse, fine, b);
    check(coarse, n, "coarse held while disabled");
    check(32'(fine), 0, "fine held while disabled");
    check(32'(b), 0, "busy bit while disabled");
  endtask

  initial begin
    rst = 1'b1;
    spi_pins = '0;
    spi_pins.cs_n = 1'b1;
    tdc_pins = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    reset_values();
    cfg_in_all_modes();
    coarse_windows();
    fine_windows();
    busy_mirror_and_disable();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
